/* src.f */
rtl/dcache_pkg.sv
rtl/cache_ctrl.sv
rtl/tag_store.sv
rtl/data_store.sv
rtl/miss_buffer.sv
rtl/dcache_top.sv
verification/tb_clock.sv
verification/bus_mem_model.sv
verification/tb_dcache.sv

/* verification/tb_dcache.sv */
// testbench top for the write-back data cache
// directed tests drive the cpu side on falling edges and check against a
// shadow copy of memory, a monitor watches the bus side every rising edge

`timescale 1ns/100ps
`default_nettype none

module tb_dcache
    import dcache_pkg::*;
;

    localparam int line_words  = 16;
    localparam int line_bits   = line_words * word_w;
    localparam int line_shift  = 6;                   // byte address bits inside a line
    localparam int mem_words   = 16384;
    localparam int mem_lines   = mem_words / line_words;
    // about 40 accesses, a miss with stalls of up to 5 costs near 110 cycles,
    // so the whole run stays well under a quarter of this
    localparam int cycle_limit = 20000;

    wire                 clk;
    wire                 resetn;
    logic                valid;
    logic                op;
    logic [addr_w-1:0]   addr;
    logic [strb_w-1:0]   wstrb;
    logic [word_w-1:0]   wdata;
    logic [3:0]          max_stall;
    wire                 addr_ok;
    wire                 data_ok;
    wire  [word_w-1:0]   rdata;
    wire                 rd_rdy;
    wire                 wr_rdy;
    wire                 ret_valid;
    wire                 ret_last;
    wire  [word_w-1:0]   ret_data;
    wire                 rd_req;
    wire                 wr_req;
    wire  [addr_w-1:0]   rd_addr;
    wire  [addr_w-1:0]   wr_addr;
    wire  [line_bits-1:0] wr_data;

    logic [word_w-1:0] shadow [mem_words];    // expected memory contents
    logic              line_stored [mem_lines];
    int error_count   = 0;
    int check_count   = 0;
    int test_count    = 0;
    int failed_tests  = 0;
    int errors_before = 0;
    int cycle_count   = 0;
    int rd_req_cycles = 0;
    int wb_count      = 0;
    int stall_cycles  = 0;
    logic              rd_waiting = 1'b0;
    logic              wr_waiting = 1'b0;
    logic [addr_w-1:0] rd_addr_q;
    logic [addr_w-1:0] wr_addr_q;

    tb_clock #(.period(100), .reset_cycles(2)) tb_clock_i (.clk(clk), .resetn(resetn));

    dcache_top #(.num_ways(4), .num_sets(32), .line_words(line_words)) dcache_top_i (
        .clk(clk), .resetn(resetn),
        .valid(valid), .op(op), .addr(addr), .wstrb(wstrb), .wdata(wdata),
        .addr_ok(addr_ok), .data_ok(data_ok), .rdata(rdata),
        .rd_rdy(rd_rdy), .wr_rdy(wr_rdy), .ret_valid(ret_valid), .ret_last(ret_last),
        .ret_data(ret_data), .rd_req(rd_req), .wr_req(wr_req),
        .rd_addr(rd_addr), .wr_addr(wr_addr), .wr_data(wr_data)
    );

    bus_mem_model #(.line_words(line_words), .mem_words(mem_words), .seed(32'he61b4006))
    bus_mem_model_i (
        .clk(clk), .resetn(resetn),
        .rd_req(rd_req), .rd_addr(rd_addr), .wr_req(wr_req), .wr_addr(wr_addr),
        .wr_data(wr_data), .max_stall(max_stall),
        .rd_rdy(rd_rdy), .wr_rdy(wr_rdy), .ret_valid(ret_valid), .ret_last(ret_last),
        .ret_data(ret_data)
    );

    function automatic logic [31:0] fill_word(input int unsigned word_idx);
        logic [31:0] byte_addr;
        byte_addr = word_idx << 2;
        return (byte_addr * 32'h9e37_79b1) ^ 32'h5bd1_e995;   // every address bit counts
    endfunction

    function automatic logic [line_bits-1:0] shadow_line(input logic [addr_w-1:0] line_addr);
        logic [line_bits-1:0] line;
        int base;
        base = (line_addr >> 2) % mem_words;
        for (int i = 0; i < line_words; i++) begin
            line[i*word_w +: word_w] = shadow[base + i];
        end
        return line;
    endfunction

    task automatic check(input string what, input logic [line_bits-1:0] got,
                         input logic [line_bits-1:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error at %0t ns: %s, got %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic start_test();
        errors_before = error_count;
    endtask

    task automatic finish_test(input string name);
        test_count++;
        if (error_count == errors_before) begin
            $display("test %s: ok", name);
        end else begin
            failed_tests++;
            $display("test %s: %0d errors", name, error_count - errors_before);
        end
    endtask

    // one request held from valid until data_ok, the shadow follows each store
    task automatic access(input logic is_store, input logic [addr_w-1:0] a,
                          input logic [strb_w-1:0] strb, input logic [word_w-1:0] d,
                          output logic [word_w-1:0] rd, output int cycles);
        int idx;
        @(negedge clk);
        valid  = 1'b1;
        op     = is_store;
        addr   = a;
        wstrb  = strb;
        wdata  = d;
        cycles = 0;
        do begin
            @(posedge clk);
            cycles++;
        end while (!data_ok);
        rd = rdata;
        if (is_store) begin
            idx = (a >> 2) % mem_words;
            for (int b = 0; b < strb_w; b++) begin
                if (strb[b]) begin
                    shadow[idx][b*8 +: 8] = d[b*8 +: 8];   // same byte lane
                end
            end
            line_stored[(a >> line_shift) % mem_lines] = 1'b1;
        end
        @(negedge clk);
        valid = 1'b0;
    endtask

    task automatic load_check(input logic [addr_w-1:0] a, input string what);
        logic [word_w-1:0] rd;
        int cycles;
        access(1'b0, a, '0, '0, rd, cycles);
        check(what, rd, shadow[(a >> 2) % mem_words]);
    endtask

    task automatic store(input logic [addr_w-1:0] a, input logic [strb_w-1:0] strb,
                         input logic [word_w-1:0] d);
        logic [word_w-1:0] rd;
        int cycles;
        access(1'b1, a, strb, d, rd, cycles);
    endtask

    task automatic test_reset_cold_miss();
        logic [addr_w-1:0] a;
        start_test();
        a = 32'h0000_0104;
        wait (resetn === 1'b1);
        @(posedge clk);
        check("addr_ok after reset", addr_ok, 1'b1);
        check("data_ok after reset", data_ok, 1'b0);
        check("rd_req after reset", rd_req, 1'b0);
        check("wr_req after reset", wr_req, 1'b0);
        @(negedge clk);
        valid = 1'b1;
        op    = 1'b0;
        addr  = a;
        @(posedge clk);
        while (!rd_req) @(posedge clk);
        check("rd_addr of the cold miss", rd_addr, a & ~32'h3f);
        while (!data_ok) @(posedge clk);
        check("cold miss load data", rdata, shadow[a >> 2]);
        @(negedge clk);
        valid = 1'b0;
        finish_test("reset and cold miss");
    endtask

    task automatic test_hits();
        logic [addr_w-1:0] hit_addr [3];
        logic [word_w-1:0] rd;
        int cycles;
        int rd_before;
        start_test();
        hit_addr  = '{32'h0000_0100, 32'h0000_0108, 32'h0000_013c};
        rd_before = rd_req_cycles;
        foreach (hit_addr[i]) begin
            access(1'b0, hit_addr[i], '0, '0, rd, cycles);
            check("hit load data", rd, shadow[hit_addr[i] >> 2]);
            check("hit load takes one cycle", cycles, 1);
        end
        check("no rd_req during hits", rd_req_cycles, rd_before);
        finish_test("hits");
    endtask

    task automatic test_strobed_stores();
        logic [strb_w-1:0] masks [4];
        logic [addr_w-1:0] a;
        start_test();
        masks = '{4'b0001, 4'b0110, 4'b1100, 4'b1111};
        for (int k = 0; k < 4; k++) begin
            a = 32'h0000_0110 + 4 * k;
            store(a, masks[k], 32'ha1b2_c3d4 ^ (32'h1111_1111 * k));
            load_check(a, "load after strobed store");
        end
        store(32'h0000_02a0, 4'b0110, 32'h7e57_0a11);   // store miss
        load_check(32'h0000_02a0, "load after store miss");
        finish_test("strobed stores");
    endtask

    task automatic test_dirty_eviction();
        logic [addr_w-1:0] a;
        int wb_before;
        start_test();
        wb_before = wb_count;
        for (int k = 0; k < 5; k++) begin
            a = 32'h0000_0240 + 32'h800 * k + 4 * k;   // set 9, a new tag each time
            store(a, (k == 2) ? 4'b0011 : 4'b1111, 32'hd00d_0000 + k);
        end
        for (int k = 0; k < 5; k++) begin
            load_check(32'h0000_0240 + 32'h800 * k + 4 * k, "load after eviction");
        end
        check("write-back happened", wb_count > wb_before, 1'b1);
        finish_test("dirty eviction");
    endtask

    task automatic test_back_pressure();
        logic [addr_w-1:0] a;
        start_test();
        @(negedge clk);
        max_stall    = 4'd5;
        stall_cycles = 0;
        for (int k = 0; k < 6; k++) begin
            a = 32'h0000_0440 + 32'h800 * k + 8 * k;   // set 17
            store(a, 4'b1001, 32'hb0b0_0000 | (k << 8) | k);
            load_check(a + 4, "load under back-pressure");
        end
        for (int k = 0; k < 6; k++) begin
            load_check(32'h0000_0440 + 32'h800 * k + 8 * k, "reload under back-pressure");
        end
        check("back-pressure exercised", stall_cycles > 0, 1'b1);
        @(negedge clk);
        max_stall = 4'd0;
        finish_test("back-pressure");
    endtask

    // bus side monitor, values here are those of the cycle that just ended
    always @(posedge clk) begin
        if (resetn) begin
            if (rd_req) rd_req_cycles++;
            if (rd_waiting) begin
                stall_cycles++;
                check("rd_req held until accepted", rd_req, 1'b1);
                check("rd_addr stable until accepted", rd_addr, rd_addr_q);
            end
            if (wr_waiting) begin
                stall_cycles++;
                check("wr_req held until accepted", wr_req, 1'b1);
                check("wr_addr stable until accepted", wr_addr, wr_addr_q);
            end
            if (wr_req && wr_rdy) begin
                wb_count++;
                check("write-back of a stored line",
                      line_stored[(wr_addr >> line_shift) % mem_lines], 1'b1);
                check("write-back line data", wr_data, shadow_line(wr_addr));
            end
            if (rd_req || wr_req || ret_valid) begin
                check("data_ok low during a miss", data_ok, 1'b0);
            end
            rd_waiting = rd_req && !rd_rdy;
            wr_waiting = wr_req && !wr_rdy;
            rd_addr_q  = rd_addr;
            wr_addr_q  = wr_addr;
        end else begin
            rd_waiting = 1'b0;
            wr_waiting = 1'b0;
        end
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= cycle_limit) begin
            $display("timeout: the run did not finish within %0d cycles", cycle_limit);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    initial begin
        valid     = 1'b0;
        op        = 1'b0;
        addr      = '0;
        wstrb     = '0;
        wdata     = '0;
        max_stall = 4'd0;
        for (int i = 0; i < mem_words; i++) begin
            shadow[i]              = fill_word(i);
            bus_mem_model_i.mem[i] = shadow[i];
        end
        for (int l = 0; l < mem_lines; l++) begin
            line_stored[l] = 1'b0;
        end
        test_reset_cold_miss();
        test_hits();
        test_strobed_stores();
        test_dirty_eviction();
        test_back_pressure();
        $display("summary: %0d tests, %0d failed, %0d checks, %0d errors, %0d write-backs",
                 test_count, failed_tests, check_count, error_count, wb_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verification/bus_mem_model.sv */
// bus side memory for the data cache testbench
// answers line read requests with a burst of beats in word order and takes
// whole-line write-backs in one transfer
// max_stall sets the longest random delay before rdy and between beats, 0 means none
// all outputs change on the falling clock edge

`timescale 1ns/100ps
`default_nettype none

module bus_mem_model #(
    parameter int          line_words = 16,
    parameter int          mem_words  = 16384,
    parameter int unsigned seed       = 32'he61b4006
) (
    input  wire                      clk,
    input  wire                      resetn,
    input  wire                      rd_req,
    input  wire  [31:0]              rd_addr,
    input  wire                      wr_req,
    input  wire  [31:0]              wr_addr,
    input  wire  [line_words*32-1:0] wr_data,
    input  wire  [3:0]               max_stall,
    output logic                     rd_rdy,
    output logic                     wr_rdy,
    output logic                     ret_valid,
    output logic                     ret_last,
    output logic [31:0]              ret_data
);

    localparam int idx_w = $clog2(mem_words);

    logic [31:0] mem [mem_words];   // loaded by the testbench at time zero

    function automatic int unsigned stall_len();
        if (max_stall == 0) begin
            return 0;
        end
        return $urandom % (max_stall + 1);
    endfunction

    task automatic wait_cycles(input int unsigned n);
        repeat (n) @(negedge clk);
    endtask

    task automatic accept_write();
        logic [idx_w-1:0] base;
        wait_cycles(stall_len());
        base   = wr_addr[idx_w+1:2];
        wr_rdy = 1'b1;
        for (int i = 0; i < line_words; i++) begin
            mem[base + i] = wr_data[i*32 +: 32];   // word 0 in the low bits
        end
        @(negedge clk);
        wr_rdy = 1'b0;
    endtask

    task automatic serve_read();
        logic [idx_w-1:0] base;
        wait_cycles(stall_len());
        base   = rd_addr[idx_w+1:2];
        rd_rdy = 1'b1;
        @(negedge clk);
        rd_rdy = 1'b0;
        for (int i = 0; i < line_words; i++) begin
            wait_cycles(stall_len());       // gap before the beat
            ret_valid = 1'b1;
            ret_data  = mem[base + i];
            ret_last  = (i == line_words - 1);
            @(negedge clk);
            ret_valid = 1'b0;
            ret_last  = 1'b0;
        end
    endtask

    initial begin : serve_loop
        int unsigned seed_v;
        seed_v    = seed;
        rd_rdy    = 1'b0;
        wr_rdy    = 1'b0;
        ret_valid = 1'b0;
        ret_last  = 1'b0;
        ret_data  = '0;
        void'($urandom(seed_v));
        forever begin
            @(negedge clk);
            if (resetn && wr_req) begin
                accept_write();
            end else if (resetn && rd_req) begin
                serve_read();
            end
        end
    end

endmodule

`default_nettype wire

/* verification/tb_clock.sv */
// clock and reset source for the data cache testbench
// resetn is held low over the first rising edges and released on a falling edge

`timescale 1ns/100ps
`default_nettype none

module tb_clock #(
    parameter int period       = 100,
    parameter int reset_cycles = 2
) (
    output logic clk,
    output logic resetn
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

    initial begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);   // reset seen on these edges
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

`default_nettype wire

/* rtl/dcache_top.sv */
// top of the write-back data cache
// cpu side valid/addr_ok/data_ok handshake, bus side line read and line write-back
// the geometry parameters are set here and handed to every block

`timescale 1ns/100ps
`default_nettype none

module dcache_top
    import dcache_pkg::*;
#(
    parameter int num_ways   = 4,
    parameter int num_sets   = 32,
    parameter int line_words = 16,
    localparam int index_w  = $clog2(num_sets),
    localparam int offset_w = $clog2(line_words),
    localparam int tag_w    = addr_w - index_w - offset_w - byte_off_w,
    localparam int way_w    = $clog2(num_ways)
) (
    input  wire                          clk,
    input  wire                          resetn,
    // cpu side
    input  wire                          valid,
    input  wire                          op,        // 0 load, 1 store
    input  wire  [addr_w-1:0]            addr,
    input  wire  [strb_w-1:0]            wstrb,
    input  wire  [word_w-1:0]            wdata,
    output logic                         addr_ok,
    output logic                         data_ok,
    output logic [word_w-1:0]            rdata,
    // bus side
    input  wire                          rd_rdy,
    input  wire                          wr_rdy,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    input  wire  [word_w-1:0]            ret_data,
    output logic                         rd_req,
    output logic                         wr_req,
    output logic [addr_w-1:0]            rd_addr,
    output logic [addr_w-1:0]            wr_addr,
    output logic [line_words*word_w-1:0] wr_data
);

    logic [tag_w-1:0]            tag;
    logic [index_w-1:0]          index;
    logic [offset_w-1:0]         word_sel;
    logic                        hit;
    logic [num_ways-1:0]         hit_way;
    logic                        sel_valid;
    logic                        sel_dirty;
    logic [tag_w-1:0]            sel_tag;
    logic [way_w-1:0]            sel_way;
    logic [line_words*word_w-1:0] victim_line;
    logic [way_w-1:0]            victim_way;
    logic                        victim_dirty;
    logic [index_w-1:0]          miss_index;
    logic [tag_w-1:0]            miss_tag;
    logic [offset_w-1:0]         refill_word;
    logic                        store_hit;
    logic                        state_refill;
    logic                        lookup_capture;

    assign tag      = addr[addr_w-1 -: tag_w];
    assign index    = addr[byte_off_w+offset_w +: index_w];
    assign word_sel = addr[byte_off_w +: offset_w];

    // the controller raises a bus request in miss and replace, so no request
    // outside refill means it sits in lookup
    assign lookup_capture = ~(rd_req | wr_req | state_refill);

    cache_ctrl cache_ctrl_i (
        .clk          (clk),
        .resetn       (resetn),
        .valid        (valid),
        .op           (op),
        .hit          (hit),
        .victim_dirty (victim_dirty),
        .rd_rdy       (rd_rdy),
        .wr_rdy       (wr_rdy),
        .ret_valid    (ret_valid),
        .ret_last     (ret_last),
        .addr_ok      (addr_ok),
        .data_ok      (data_ok),
        .rd_req       (rd_req),
        .wr_req       (wr_req),
        .store_hit    (store_hit),
        .state_refill (state_refill)
    );

    tag_store #(
        .num_ways   (num_ways),
        .num_sets   (num_sets),
        .line_words (line_words)
    ) tag_store_i (
        .clk        (clk),
        .resetn     (resetn),
        .tag        (tag),
        .index      (index),
        .store_hit  (store_hit),
        .ret_valid  (ret_valid),
        .ret_last   (ret_last),
        .victim_way (victim_way),
        .miss_index (miss_index),
        .miss_tag   (miss_tag),
        .sel_way    (sel_way),
        .hit        (hit),
        .hit_way    (hit_way),
        .sel_valid  (sel_valid),
        .sel_dirty  (sel_dirty),
        .sel_tag    (sel_tag)
    );

    data_store #(
        .num_ways   (num_ways),
        .num_sets   (num_sets),
        .line_words (line_words)
    ) data_store_i (
        .clk         (clk),
        .index       (index),
        .word_sel    (word_sel),
        .hit_way     (hit_way),
        .store_hit   (store_hit),
        .wstrb       (wstrb),
        .wdata       (wdata),
        .ret_valid   (ret_valid),
        .ret_data    (ret_data),
        .victim_way  (victim_way),
        .miss_index  (miss_index),
        .refill_word (refill_word),
        .sel_way     (sel_way),
        .rdata       (rdata),
        .victim_line (victim_line)
    );

    miss_buffer #(
        .num_ways   (num_ways),
        .num_sets   (num_sets),
        .line_words (line_words)
    ) miss_buffer_i (
        .clk            (clk),
        .resetn         (resetn),
        .lookup_capture (lookup_capture),
        .state_refill   (state_refill),
        .tag            (tag),
        .index          (index),
        .sel_valid      (sel_valid),
        .sel_dirty      (sel_dirty),
        .sel_tag        (sel_tag),
        .victim_line    (victim_line),
        .ret_valid      (ret_valid),
        .ret_last       (ret_last),
        .sel_way        (sel_way),
        .victim_way     (victim_way),
        .victim_dirty   (victim_dirty),
        .miss_index     (miss_index),
        .miss_tag       (miss_tag),
        .refill_word    (refill_word),
        .rd_addr        (rd_addr),
        .wr_addr        (wr_addr),
        .wr_data        (wr_data)
    );

endmodule

`default_nettype wire

/* rtl/miss_buffer.sv */
// miss buffer of the data cache
// a free-running counter picks the victim way, the victim entry and the request
// are captured every lookup cycle, and the last capture serves the miss
// also counts refill beats and forms the line-aligned bus addresses

`timescale 1ns/100ps
`default_nettype none

module miss_buffer
    import dcache_pkg::*;
#(
    parameter int num_ways   = 4,
    parameter int num_sets   = 32,
    parameter int line_words = 16,
    localparam int index_w    = $clog2(num_sets),
    localparam int offset_w   = $clog2(line_words),
    localparam int line_off_w = offset_w + byte_off_w,
    localparam int tag_w      = addr_w - index_w - line_off_w,
    localparam int way_w      = $clog2(num_ways)
) (
    input  wire                          clk,
    input  wire                          resetn,
    input  wire                          lookup_capture,
    input  wire                          state_refill,
    input  wire  [tag_w-1:0]             tag,
    input  wire  [index_w-1:0]           index,
    input  wire                          sel_valid,
    input  wire                          sel_dirty,
    input  wire  [tag_w-1:0]             sel_tag,
    input  wire  [line_words*word_w-1:0] victim_line,
    input  wire                          ret_valid,
    input  wire                          ret_last,
    output logic [way_w-1:0]             sel_way,
    output logic [way_w-1:0]             victim_way,
    output logic                         victim_dirty,
    output logic [index_w-1:0]           miss_index,
    output logic [tag_w-1:0]             miss_tag,
    output logic [offset_w-1:0]          refill_word,
    output logic [addr_w-1:0]            rd_addr,
    output logic [addr_w-1:0]            wr_addr,
    output logic [line_words*word_w-1:0] wr_data
);

    logic [tag_w-1:0] victim_tag;   // old tag, needed for the write-back address

    // pseudo-random victim, wraps for a power-of-two way count
    always_ff @(posedge clk) begin
        if (!resetn) begin
            sel_way <= '0;
        end else begin
            sel_way <= sel_way + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!resetn) begin
            victim_dirty <= 1'b0;
        end else if (lookup_capture) begin
            victim_dirty <= sel_valid & sel_dirty;   // only a valid line needs write-back
        end
    end

    always_ff @(posedge clk) begin
        if (lookup_capture) begin
            victim_way <= sel_way;
            victim_tag <= sel_tag;
            miss_index <= index;
            miss_tag   <= tag;
            wr_data    <= victim_line;
        end
    end

    // restarts at zero on every entry to refill
    always_ff @(posedge clk) begin
        if (!resetn || !state_refill) begin
            refill_word <= '0;
        end else if (ret_valid) begin
            refill_word <= refill_word + 1'b1;
        end
    end

    assign rd_addr = {miss_tag, miss_index, line_off_w'(0)};
    assign wr_addr = {victim_tag, miss_index, line_off_w'(0)};

    // the bus must deliver exactly line_words beats per burst
    a_last_beat: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid && ret_last |-> refill_word == offset_w'(line_words - 1));

endmodule

`default_nettype wire

/* rtl/data_store.sv */
// line storage of the data cache, one line per way and set
// hit loads read one word of the hitting way, hit stores merge the strobed bytes,
// refill beats fill the victim line word by word
// the whole line of the counter-selected way is read out for the write-back

`timescale 1ns/100ps
`default_nettype none

module data_store
    import dcache_pkg::*;
#(
    parameter int num_ways   = 4,
    parameter int num_sets   = 32,
    parameter int line_words = 16,
    localparam int index_w  = $clog2(num_sets),
    localparam int offset_w = $clog2(line_words),
    localparam int way_w    = $clog2(num_ways)
) (
    input  wire                          clk,
    input  wire  [index_w-1:0]           index,
    input  wire  [offset_w-1:0]          word_sel,
    input  wire  [num_ways-1:0]          hit_way,
    input  wire                          store_hit,
    input  wire  [strb_w-1:0]            wstrb,
    input  wire  [word_w-1:0]            wdata,
    input  wire                          ret_valid,
    input  wire  [word_w-1:0]            ret_data,
    input  wire  [way_w-1:0]             victim_way,
    input  wire  [index_w-1:0]           miss_index,
    input  wire  [offset_w-1:0]          refill_word,
    input  wire  [way_w-1:0]             sel_way,
    output logic [word_w-1:0]            rdata,
    output logic [line_words*word_w-1:0] victim_line
);

    localparam int byte_w = word_w / strb_w;

    logic [word_w-1:0] line_q [num_ways][num_sets][line_words];

    // hit_way is one-hot, so an or over the ways picks the hitting word
    always_comb begin
        rdata = '0;
        for (int w = 0; w < num_ways; w++) begin
            if (hit_way[w]) begin
                rdata = rdata | line_q[w][index][word_sel];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (store_hit) begin
            for (int w = 0; w < num_ways; w++) begin
                if (hit_way[w]) begin
                    for (int b = 0; b < strb_w; b++) begin
                        if (wstrb[b]) begin
                            // strobe bit b writes byte lane b of wdata, no shifting
                            line_q[w][index][word_sel][b*byte_w +: byte_w] <=
                                wdata[b*byte_w +: byte_w];
                        end
                    end
                end
            end
        end else if (ret_valid) begin
            line_q[victim_way][miss_index][refill_word] <= ret_data;   // one beat per word
        end
    end

    // word 0 sits in the low bits of the line
    always_comb begin
        for (int i = 0; i < line_words; i++) begin
            victim_line[i*word_w +: word_w] = line_q[sel_way][index][i];
        end
    end

endmodule

`default_nettype wire

/* rtl/tag_store.sv */
// valid, dirty and tag arrays of the data cache, one entry per way and set
// compares all ways of the addressed set at once and reads the entry of the way
// the victim counter points at, for the miss buffer

`timescale 1ns/100ps
`default_nettype none

module tag_store
    import dcache_pkg::*;
#(
    parameter int num_ways   = 4,
    parameter int num_sets   = 32,
    parameter int line_words = 16,
    localparam int index_w  = $clog2(num_sets),
    localparam int offset_w = $clog2(line_words),
    localparam int tag_w    = addr_w - index_w - offset_w - byte_off_w,
    localparam int way_w    = $clog2(num_ways)
) (
    input  wire                 clk,
    input  wire                 resetn,
    input  wire  [tag_w-1:0]    tag,
    input  wire  [index_w-1:0]  index,
    input  wire                 store_hit,
    input  wire                 ret_valid,
    input  wire                 ret_last,
    input  wire  [way_w-1:0]    victim_way,
    input  wire  [index_w-1:0]  miss_index,
    input  wire  [tag_w-1:0]    miss_tag,
    input  wire  [way_w-1:0]    sel_way,
    output logic                hit,
    output logic [num_ways-1:0] hit_way,
    output logic                sel_valid,
    output logic                sel_dirty,
    output logic [tag_w-1:0]    sel_tag
);

    logic [num_ways-1:0] valid_q [num_sets];   // one bit per way
    logic [num_ways-1:0] dirty_q [num_sets];
    logic [tag_w-1:0]    tag_q   [num_ways][num_sets];
    logic                refill_done;          // last beat of a line

    assign refill_done = ret_valid & ret_last;

    always_comb begin
        for (int w = 0; w < num_ways; w++) begin
            hit_way[w] = valid_q[index][w] && (tag_q[w][index] == tag);
        end
    end

    assign hit = |hit_way;

    // entry the victim counter selects in the requested set
    assign sel_valid = valid_q[index][sel_way];
    assign sel_dirty = dirty_q[index][sel_way];
    assign sel_tag   = tag_q[sel_way][index];

    always_ff @(posedge clk) begin
        if (!resetn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end else if (store_hit) begin
            dirty_q[index] <= dirty_q[index] | hit_way;
        end else if (refill_done) begin
            // line is complete only now, earlier beats leave it invalid
            valid_q[miss_index][victim_way] <= 1'b1;
            dirty_q[miss_index][victim_way] <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (refill_done) begin
            tag_q[victim_way][miss_index] <= miss_tag;
        end
    end

    // a refill never installs a tag that another way of the set still holds
    a_hit_onehot: assert property (@(posedge clk) disable iff (!resetn)
        $onehot0(hit_way));

endmodule

`default_nettype wire

/* rtl/cache_ctrl.sv */
// main controller of the data cache
// lookup serves hits in one cycle and a miss walks through miss, replace and refill
// cpu handshake and bus requests are decoded from the state register

`timescale 1ns/100ps
`default_nettype none

module cache_ctrl
    import dcache_pkg::*;
(
    input  wire  clk,
    input  wire  resetn,
    input  wire  valid,
    input  wire  op,
    input  wire  hit,
    input  wire  victim_dirty,
    input  wire  rd_rdy,
    input  wire  wr_rdy,
    input  wire  ret_valid,
    input  wire  ret_last,
    output logic addr_ok,
    output logic data_ok,
    output logic rd_req,
    output logic wr_req,
    output logic store_hit,
    output logic state_refill
);

    ctrl_state_t state;
    ctrl_state_t state_nxt;
    logic        in_lookup;
    logic        lookup_hit;     // request served this cycle
    logic        lookup_miss;    // request leaves lookup at the edge

    assign in_lookup   = (state == lookup);
    assign lookup_hit  = in_lookup & valid & hit;
    assign lookup_miss = in_lookup & valid & ~hit;

    always_ff @(posedge clk) begin
        if (!resetn) begin
            state <= lookup;
        end else begin
            state <= state_nxt;
        end
    end

    always_comb begin
        state_nxt = state;
        case (state)
            lookup: begin
                if (lookup_miss) begin
                    state_nxt = miss;
                end
            end
            miss: begin
                if (victim_dirty && wr_rdy) begin
                    state_nxt = replace;     // write-back accepted
                end else if (!victim_dirty && rd_rdy) begin
                    state_nxt = refill;      // clean victim goes straight to the read
                end
            end
            replace: begin
                if (rd_rdy) begin
                    state_nxt = refill;
                end
            end
            refill: begin
                if (ret_valid && ret_last) begin
                    state_nxt = lookup;
                end
            end
            default: state_nxt = lookup;
        endcase
    end

    assign addr_ok      = in_lookup & ~lookup_miss;
    assign data_ok      = lookup_hit;
    assign store_hit    = lookup_hit & op;
    assign wr_req       = (state == miss) & victim_dirty;
    assign rd_req       = ((state == miss) & ~victim_dirty) | (state == replace);
    assign state_refill = (state == refill);

    // beats only come back for a burst that was asked for
    a_ret_in_refill: assert property (@(posedge clk) disable iff (!resetn)
        ret_valid |-> state == refill);

    // a request waiting for its rdy holds, which needs a steady victim_dirty
    a_req_held: assert property (@(posedge clk) disable iff (!resetn)
        (rd_req && !rd_rdy) || (wr_req && !wr_rdy) |=> $stable({rd_req, wr_req}));

endmodule

`default_nettype wire

/* rtl/dcache_pkg.sv */
// shared widths and types of the write-back data cache
// imported by wildcard into each cache block that needs them
// geometry (ways, sets, words per line) is set by module parameters instead

`default_nettype none

package dcache_pkg;

    // cpu and bus side widths
    localparam int word_w = 32;     // one cpu word, also one bus beat
    localparam int addr_w = 32;     // byte address

    // byte lanes inside a word
    localparam int strb_w     = word_w / 8;         // one strobe bit per byte lane
    localparam int byte_off_w = $clog2(strb_w);     // low address bits below the word

    // controller states
    //   lookup  : tag compare, hits complete here
    //   miss    : victim known, bus request raised
    //   replace : dirty victim written back, line read requested
    //   refill  : line beats arriving from the bus
    typedef enum logic [1:0] {
        lookup  = 2'd0,
        miss    = 2'd1,
        replace = 2'd2,
        refill  = 2'd3
    } ctrl_state_t;

endpackage

`default_nettype wire
